/* hdl/l2_pkg.sv */
package l2_pkg;

	// Word address into the 64-word store
	typedef logic [5:0] l2_addr_t;

	typedef logic [31:0] l2_data_t;	// One data word

	// Byte enables, bit n enables byte n
	typedef logic [3:0] l2_mask_t;

	typedef logic [2:0] l2_op_t;	// Operation code
	typedef logic [1:0] strand_t;	// Strand tag of the requester
	typedef logic core_t;	// Core index

	typedef logic [15:0] pc_count_t;	// Performance counter value

	localparam int NUM_CORES = 2;	// Cores on the request side

	// Operation codes, everything else is rejected
	localparam l2_op_t OP_LOAD = 3'd0;
	localparam l2_op_t OP_STORE = 3'd1;

endpackage

/* hdl/l2_request_queue.sv */
`timescale 1ns/1ps

module l2_request_queue #(
	parameter int REQ_CREDITS = 4
) (
	input logic reset,	// Clock
	input logic clk,	// Async reset, active high
	input logic push,
	input l2_pkg::strand_t push_strand,
	input l2_pkg::l2_op_t push_op,
	input l2_pkg::l2_addr_t push_address,
	input l2_pkg::l2_data_t push_data,
	input l2_pkg::l2_mask_t push_mask,
	input logic pop,
	output logic not_empty,
	output l2_pkg::strand_t head_strand,
	output l2_pkg::l2_op_t head_op,
	output l2_pkg::l2_addr_t head_address,
	output l2_pkg::l2_data_t head_data,
	output l2_pkg::l2_mask_t head_mask,
	output logic credit_return
);
	import l2_pkg::*;

	localparam int PTR_W = (REQ_CREDITS > 1) ? $clog2(REQ_CREDITS) : 1;
	localparam int CNT_W = $clog2(REQ_CREDITS + 1);
	localparam logic [PTR_W-1:0] LAST = PTR_W'(REQ_CREDITS - 1);	// Pointer wrap point

	strand_t strand_mem [REQ_CREDITS];	// One slot per credit
	l2_op_t op_mem [REQ_CREDITS];
	l2_addr_t address_mem [REQ_CREDITS];
	l2_data_t data_mem [REQ_CREDITS];
	l2_mask_t mask_mem [REQ_CREDITS];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;	// Occupied entries

	always_ff @(posedge reset or posedge clk)
	begin
		if (clk)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;	// Circular wrap
			if (pop)
				rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;	// Simultaneous push and pop keeps count
		end
	end

	always_ff @(posedge reset)
	begin
		if (push)
		begin
			strand_mem[wr_ptr] <= push_strand;	// Payload only, no reset
			op_mem[wr_ptr] <= push_op;
			address_mem[wr_ptr] <= push_address;
			data_mem[wr_ptr] <= push_data;
			mask_mem[wr_ptr] <= push_mask;
		end
	end

	assign not_empty = (count != '0);
	assign head_strand = strand_mem[rd_ptr];	// Head visible without a read cycle
	assign head_op = op_mem[rd_ptr];
	assign head_address = address_mem[rd_ptr];
	assign head_data = data_mem[rd_ptr];
	assign head_mask = mask_mem[rd_ptr];
	assign credit_return = pop;	// Slot freed, credit goes back to the core

endmodule

/* hdl/l2_arbiter.sv */
`timescale 1ns/1ps

module l2_arbiter #(
	parameter int REQ_CREDITS = 4
) (
	input logic reset,	// Clock
	input logic clk,	// Async reset
	input logic req_valid_0,
	input l2_pkg::strand_t req_strand_0,
	input l2_pkg::l2_op_t req_op_0,
	input l2_pkg::l2_addr_t req_address_0,
	input l2_pkg::l2_data_t req_data_0,
	input l2_pkg::l2_mask_t req_mask_0,
	input logic req_valid_1,
	input l2_pkg::strand_t req_strand_1,
	input l2_pkg::l2_op_t req_op_1,
	input l2_pkg::l2_addr_t req_address_1,
	input l2_pkg::l2_data_t req_data_1,
	input l2_pkg::l2_mask_t req_mask_1,
	output logic credit_return_0,
	output logic credit_return_1,
	output logic grant_valid,
	output l2_pkg::core_t grant_core,
	output l2_pkg::strand_t grant_strand,
	output l2_pkg::l2_op_t grant_op,
	output l2_pkg::l2_addr_t grant_address,
	output l2_pkg::l2_data_t grant_data,
	output l2_pkg::l2_mask_t grant_mask
);
	import l2_pkg::*;

	logic not_empty_0;
	logic not_empty_1;
	strand_t head_strand_0;
	strand_t head_strand_1;
	l2_op_t head_op_0;
	l2_op_t head_op_1;
	l2_addr_t head_address_0;
	l2_addr_t head_address_1;
	l2_data_t head_data_0;
	l2_data_t head_data_1;
	l2_mask_t head_mask_0;
	l2_mask_t head_mask_1;
	core_t last_granted;	// Round-robin history
	core_t sel;	// Queue picked this cycle

	l2_request_queue #(.REQ_CREDITS(REQ_CREDITS)) i_queue_0 (
		.reset(reset),
		.clk(clk),
		.push(req_valid_0),
		.push_strand(req_strand_0),
		.push_op(req_op_0),
		.push_address(req_address_0),
		.push_data(req_data_0),
		.push_mask(req_mask_0),
		.pop(grant_valid && (sel == 1'b0)),
		.not_empty(not_empty_0),
		.head_strand(head_strand_0),
		.head_op(head_op_0),
		.head_address(head_address_0),
		.head_data(head_data_0),
		.head_mask(head_mask_0),
		.credit_return(credit_return_0)
	);

	l2_request_queue #(.REQ_CREDITS(REQ_CREDITS)) i_queue_1 (
		.reset(reset),
		.clk(clk),
		.push(req_valid_1),
		.push_strand(req_strand_1),
		.push_op(req_op_1),
		.push_address(req_address_1),
		.push_data(req_data_1),
		.push_mask(req_mask_1),
		.pop(grant_valid && (sel == 1'b1)),
		.not_empty(not_empty_1),
		.head_strand(head_strand_1),
		.head_op(head_op_1),
		.head_address(head_address_1),
		.head_data(head_data_1),
		.head_mask(head_mask_1),
		.credit_return(credit_return_1)
	);

	// Both waiting: take the one not granted last, otherwise whoever has work
	assign sel = (not_empty_0 && not_empty_1) ? ~last_granted : not_empty_1;
	assign grant_valid = not_empty_0 || not_empty_1;
	assign grant_core = sel;
	assign grant_strand = sel ? head_strand_1 : head_strand_0;
	assign grant_op = sel ? head_op_1 : head_op_0;
	assign grant_address = sel ? head_address_1 : head_address_0;
	assign grant_data = sel ? head_data_1 : head_data_0;
	assign grant_mask = sel ? head_mask_1 : head_mask_0;

	always_ff @(posedge reset or posedge clk)
	begin
		if (clk)
			last_granted <= 1'b1;	// Core 0 wins the first tie
		else if (grant_valid)
			last_granted <= sel;
	end

endmodule

/* hdl/l2_decode.sv */
`timescale 1ns/1ps

module l2_decode (
	input logic reset,	// Clock
	input logic clk,	// Async reset
	input logic grant_valid,
	input l2_pkg::core_t grant_core,
	input l2_pkg::strand_t grant_strand,
	input l2_pkg::l2_op_t grant_op,
	input l2_pkg::l2_addr_t grant_address,
	input l2_pkg::l2_data_t grant_data,
	input l2_pkg::l2_mask_t grant_mask,
	output logic dec_valid,
	output l2_pkg::core_t dec_core,
	output l2_pkg::strand_t dec_strand,
	output l2_pkg::l2_addr_t dec_address,
	output l2_pkg::l2_data_t dec_data,
	output l2_pkg::l2_mask_t dec_mask,
	output l2_pkg::l2_op_t dec_op,
	output logic dec_is_load,
	output logic dec_is_store
);
	import l2_pkg::*;

	always_ff @(posedge reset or posedge clk)
	begin
		if (clk)
		begin
			dec_valid <= 1'b0;
			dec_is_load <= 1'b0;
			dec_is_store <= 1'b0;
		end
		else
		begin
			dec_valid <= grant_valid;
			dec_is_load <= grant_valid && (grant_op == OP_LOAD);	// Qualified by valid
			dec_is_store <= grant_valid && (grant_op == OP_STORE);
			// Unknown codes leave both flags low and get rejected downstream
		end
	end

	always_ff @(posedge reset)
	begin
		dec_core <= grant_core;	// Payload follows the grant unconditionally
		dec_strand <= grant_strand;
		dec_op <= grant_op;
		dec_address <= grant_address;
		dec_data <= grant_data;
		dec_mask <= grant_mask;
	end

endmodule

/* hdl/l2_execute.sv */
`timescale 1ns/1ps

module l2_execute (
	input logic reset,	// Clock
	input logic clk,	// Async reset
	input logic dec_valid,
	input l2_pkg::core_t dec_core,
	input l2_pkg::strand_t dec_strand,
	input l2_pkg::l2_addr_t dec_address,
	input l2_pkg::l2_data_t dec_data,
	input l2_pkg::l2_mask_t dec_mask,
	input l2_pkg::l2_op_t dec_op,
	input logic dec_is_load,
	input logic dec_is_store,
	output logic exe_valid,
	output l2_pkg::core_t exe_core,
	output l2_pkg::strand_t exe_strand,
	output l2_pkg::l2_op_t exe_op,
	output l2_pkg::l2_addr_t exe_address,
	output logic exe_status,
	output l2_pkg::l2_data_t exe_word,
	output logic exe_event_load,
	output logic exe_event_store,
	output logic exe_event_error
);
	import l2_pkg::*;

	localparam int WORDS = 1 << $bits(l2_addr_t);	// 64 words
	localparam int BYTES = $bits(l2_mask_t);

	l2_data_t mem [WORDS];
	l2_data_t merged_word;	// Old word with masked bytes replaced

	always_comb
	begin
		merged_word = mem[dec_address];
		for (int b = 0; b < BYTES; b++)
		begin
			if (dec_mask[b])
				merged_word[b*8 +: 8] = dec_data[b*8 +: 8];
		end
	end

	// Array is cleared at reset, store writes the merged word
	always_ff @(posedge reset or posedge clk)
	begin
		if (clk)
		begin
			for (int i = 0; i < WORDS; i++)
				mem[i] <= '0;
		end
		else if (dec_valid && dec_is_store)
			mem[dec_address] <= merged_word;	// Visible to a load on the next cycle
	end

	always_ff @(posedge reset or posedge clk)
	begin
		if (clk)
		begin
			exe_valid <= 1'b0;
			exe_event_load <= 1'b0;
			exe_event_store <= 1'b0;
			exe_event_error <= 1'b0;
		end
		else
		begin
			exe_valid <= dec_valid;
			exe_event_load <= dec_valid && dec_is_load;
			exe_event_store <= dec_valid && dec_is_store;
			exe_event_error <= dec_valid && !dec_is_load && !dec_is_store;	// Rejected op
		end
	end

	always_ff @(posedge reset)
	begin
		exe_core <= dec_core;
		exe_strand <= dec_strand;
		exe_op <= dec_op;
		exe_address <= dec_address;
		exe_status <= dec_is_load || dec_is_store;	// Zero on rejection
		if (dec_is_store)
			exe_word <= merged_word;	// Store returns the merged word
		else if (dec_is_load)
			exe_word <= mem[dec_address];
		else
			exe_word <= '0;
	end

endmodule

/* hdl/l2_result.sv */
`timescale 1ns/1ps

module l2_result (
	input logic reset,	// Clock
	input logic clk,	// Async reset
	input logic exe_valid,
	input l2_pkg::core_t exe_core,
	input l2_pkg::strand_t exe_strand,
	input l2_pkg::l2_op_t exe_op,
	input l2_pkg::l2_addr_t exe_address,
	input logic exe_status,
	input l2_pkg::l2_data_t exe_word,
	output logic rsp_valid,
	output l2_pkg::core_t rsp_core,
	output l2_pkg::strand_t rsp_strand,
	output l2_pkg::l2_op_t rsp_op,
	output logic rsp_status,
	output l2_pkg::l2_addr_t rsp_address,
	output l2_pkg::l2_data_t rsp_data,
	output logic [l2_pkg::NUM_CORES-1:0] rsp_update
);
	import l2_pkg::*;

	logic [NUM_CORES-1:0] update_next;	// Cores that must refresh their copy

	always_comb
	begin
		update_next = '0;
		if (exe_valid && exe_status)
		begin
			if (exe_op == OP_LOAD)
				update_next[exe_core] = 1'b1;	// Requester only
			else
				update_next = '1;	// Store, every core refreshes
		end
	end

	always_ff @(posedge reset or posedge clk)
	begin
		if (clk)
		begin
			rsp_valid <= 1'b0;
			rsp_update <= '0;
		end
		else
		begin
			rsp_valid <= exe_valid;
			rsp_update <= update_next;
		end
	end

	always_ff @(posedge reset)
	begin
		rsp_core <= exe_core;	// Broadcast fields, filtered by rsp_core at the cores
		rsp_strand <= exe_strand;
		rsp_op <= exe_op;
		rsp_status <= exe_status;
		rsp_address <= exe_address;
		rsp_data <= exe_word;
	end

endmodule

/* hdl/performance_counters.sv */
`timescale 1ns/1ps

module performance_counters #(
	parameter int NUM_COUNTERS = 3
) (
	input logic reset,	// Clock
	input logic clk,	// Async reset
	input logic [NUM_COUNTERS-1:0] pc_event,
	output l2_pkg::pc_count_t [NUM_COUNTERS-1:0] pc_count
);

	always_ff @(posedge reset or posedge clk)
	begin
		if (clk)
			pc_count <= '0;
		else
		begin
			for (int i = 0; i < NUM_COUNTERS; i++)
			begin
				// Hold at all ones instead of wrapping
				if (pc_event[i] && (pc_count[i] != '1))
					pc_count[i] <= pc_count[i] + 1'b1;
			end
		end
	end

endmodule

/* hdl/l2_subsystem.sv */
`timescale 1ns/1ps

module l2_subsystem #(
	parameter int REQ_CREDITS = 4
) (
	input logic reset,	// Clock
	input logic clk,	// Async reset, active high
	input logic req_valid_0,
	input l2_pkg::strand_t req_strand_0,
	input l2_pkg::l2_op_t req_op_0,
	input l2_pkg::l2_addr_t req_address_0,
	input l2_pkg::l2_data_t req_data_0,
	input l2_pkg::l2_mask_t req_mask_0,
	input logic req_valid_1,
	input l2_pkg::strand_t req_strand_1,
	input l2_pkg::l2_op_t req_op_1,
	input l2_pkg::l2_addr_t req_address_1,
	input l2_pkg::l2_data_t req_data_1,
	input l2_pkg::l2_mask_t req_mask_1,
	output logic credit_return_0,
	output logic credit_return_1,
	output logic rsp_valid,
	output l2_pkg::core_t rsp_core,
	output l2_pkg::strand_t rsp_strand,
	output l2_pkg::l2_op_t rsp_op,
	output logic rsp_status,
	output l2_pkg::l2_addr_t rsp_address,
	output l2_pkg::l2_data_t rsp_data,
	output logic [l2_pkg::NUM_CORES-1:0] rsp_update,
	output l2_pkg::pc_count_t pc_load_count,
	output l2_pkg::pc_count_t pc_store_count,
	output l2_pkg::pc_count_t pc_error_count
);
	import l2_pkg::*;

	localparam int NUM_COUNTERS = 3;	// Load, store, error

	logic grant_valid;	// Arbiter to decode
	core_t grant_core;
	strand_t grant_strand;
	l2_op_t grant_op;
	l2_addr_t grant_address;
	l2_data_t grant_data;
	l2_mask_t grant_mask;
	logic dec_valid;	// Decode to execute
	core_t dec_core;
	strand_t dec_strand;
	l2_addr_t dec_address;
	l2_data_t dec_data;
	l2_mask_t dec_mask;
	l2_op_t dec_op;
	logic dec_is_load;
	logic dec_is_store;
	logic exe_valid;	// Execute to result
	core_t exe_core;
	strand_t exe_strand;
	l2_op_t exe_op;
	l2_addr_t exe_address;
	logic exe_status;
	l2_data_t exe_word;
	logic exe_event_load;
	logic exe_event_store;
	logic exe_event_error;
	pc_count_t [NUM_COUNTERS-1:0] pc_count;

	l2_arbiter #(.REQ_CREDITS(REQ_CREDITS)) i_l2_arbiter (
		.reset(reset),
		.clk(clk),
		.req_valid_0(req_valid_0),
		.req_strand_0(req_strand_0),
		.req_op_0(req_op_0),
		.req_address_0(req_address_0),
		.req_data_0(req_data_0),
		.req_mask_0(req_mask_0),
		.req_valid_1(req_valid_1),
		.req_strand_1(req_strand_1),
		.req_op_1(req_op_1),
		.req_address_1(req_address_1),
		.req_data_1(req_data_1),
		.req_mask_1(req_mask_1),
		.credit_return_0(credit_return_0),
		.credit_return_1(credit_return_1),
		.grant_valid(grant_valid),
		.grant_core(grant_core),
		.grant_strand(grant_strand),
		.grant_op(grant_op),
		.grant_address(grant_address),
		.grant_data(grant_data),
		.grant_mask(grant_mask)
	);

	l2_decode i_l2_decode (
		.reset(reset),
		.clk(clk),
		.grant_valid(grant_valid),
		.grant_core(grant_core),
		.grant_strand(grant_strand),
		.grant_op(grant_op),
		.grant_address(grant_address),
		.grant_data(grant_data),
		.grant_mask(grant_mask),
		.dec_valid(dec_valid),
		.dec_core(dec_core),
		.dec_strand(dec_strand),
		.dec_address(dec_address),
		.dec_data(dec_data),
		.dec_mask(dec_mask),
		.dec_op(dec_op),
		.dec_is_load(dec_is_load),
		.dec_is_store(dec_is_store)
	);

	l2_execute i_l2_execute (
		.reset(reset),
		.clk(clk),
		.dec_valid(dec_valid),
		.dec_core(dec_core),
		.dec_strand(dec_strand),
		.dec_address(dec_address),
		.dec_data(dec_data),
		.dec_mask(dec_mask),
		.dec_op(dec_op),
		.dec_is_load(dec_is_load),
		.dec_is_store(dec_is_store),
		.exe_valid(exe_valid),
		.exe_core(exe_core),
		.exe_strand(exe_strand),
		.exe_op(exe_op),
		.exe_address(exe_address),
		.exe_status(exe_status),
		.exe_word(exe_word),
		.exe_event_load(exe_event_load),
		.exe_event_store(exe_event_store),
		.exe_event_error(exe_event_error)
	);

	l2_result i_l2_result (
		.reset(reset),
		.clk(clk),
		.exe_valid(exe_valid),
		.exe_core(exe_core),
		.exe_strand(exe_strand),
		.exe_op(exe_op),
		.exe_address(exe_address),
		.exe_status(exe_status),
		.exe_word(exe_word),
		.rsp_valid(rsp_valid),
		.rsp_core(rsp_core),
		.rsp_strand(rsp_strand),
		.rsp_op(rsp_op),
		.rsp_status(rsp_status),
		.rsp_address(rsp_address),
		.rsp_data(rsp_data),
		.rsp_update(rsp_update)
	);

	performance_counters #(.NUM_COUNTERS(NUM_COUNTERS)) i_performance_counters (
		.reset(reset),
		.clk(clk),
		.pc_event({exe_event_error, exe_event_store, exe_event_load}),	// Bit 0 is loads
		.pc_count(pc_count)
	);

	assign pc_load_count = pc_count[0];
	assign pc_store_count = pc_count[1];
	assign pc_error_count = pc_count[2];

endmodule

/* verif/l2_checker.sv */
`timescale 1ns/1ps

module l2_checker (
	input logic reset,	// Clock
	input logic clk,	// Async reset, active high
	input logic req_valid_0,
	input l2_pkg::strand_t req_strand_0,
	input l2_pkg::l2_op_t req_op_0,
	input l2_pkg::l2_addr_t req_address_0,
	input l2_pkg::l2_data_t req_data_0,
	input l2_pkg::l2_mask_t req_mask_0,
	input logic req_valid_1,
	input l2_pkg::strand_t req_strand_1,
	input l2_pkg::l2_op_t req_op_1,
	input l2_pkg::l2_addr_t req_address_1,
	input l2_pkg::l2_data_t req_data_1,
	input l2_pkg::l2_mask_t req_mask_1,
	input logic credit_return_0,
	input logic credit_return_1,
	input logic rsp_valid,
	input l2_pkg::core_t rsp_core,
	input l2_pkg::strand_t rsp_strand,
	input l2_pkg::l2_op_t rsp_op,
	input logic rsp_status,
	input l2_pkg::l2_addr_t rsp_address,
	input l2_pkg::l2_data_t rsp_data,
	input logic [l2_pkg::NUM_CORES-1:0] rsp_update,
	input l2_pkg::pc_count_t pc_load_count,
	input l2_pkg::pc_count_t pc_store_count,
	input l2_pkg::pc_count_t pc_error_count,
	input logic end_check,	// Request for the closing comparisons
	output logic end_done,
	output int pending,	// Requests still waiting for a response
	output int error_count,
	output int rsp_count
);
	import l2_pkg::*;

	typedef struct packed {
		strand_t strand;
		l2_op_t op;
		l2_addr_t address;
		l2_data_t data;
		l2_mask_t mask;
	} request_t;

	request_t queue_0 [$];	// Outstanding requests of core 0, oldest first
	request_t queue_1 [$];
	l2_data_t model_mem [64];	// Reference copy of the store
	int accepted [2];	// Requests sent per core
	int credits_back [2];	// credit_return pulses per core
	int loads;
	int stores;
	int rejects;

	// Byte mask widened to a bit mask, then old and new words blended
	function automatic l2_data_t apply_mask(input l2_data_t old_word, input l2_data_t new_word,
		input l2_mask_t mask);
		l2_data_t keep;
		keep = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
		return (old_word & ~keep) | (new_word & keep);
	endfunction

	task automatic compare(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
		begin
			$display("CHECK FAILED %s: got %h, expected %h", name, got, expected);
			error_count++;
		end
	endtask

	task automatic check_response();
		request_t head;
		l2_data_t exp_data;
		logic exp_status;
		logic [1:0] exp_update;
		if ((rsp_core == 1'b0 && queue_0.size() == 0)
			|| (rsp_core == 1'b1 && queue_1.size() == 0))
		begin
			$display("Response for core %0d arrived with no request outstanding", rsp_core);
			error_count++;
		end
		else
		begin
			if (rsp_core)
				head = queue_1.pop_front();	// Oldest request of that core
			else
				head = queue_0.pop_front();
			exp_data = '0;	// Rejected op defaults
			exp_status = 1'b0;
			exp_update = 2'b00;
			if (head.op == OP_LOAD)
			begin
				exp_data = model_mem[head.address];
				exp_status = 1'b1;
				exp_update = rsp_core ? 2'b10 : 2'b01;	// Requester only
				loads++;
			end
			else if (head.op == OP_STORE)
			begin
				exp_data = apply_mask(model_mem[head.address], head.data, head.mask);
				model_mem[head.address] = exp_data;	// Response order is execution order
				exp_status = 1'b1;
				exp_update = 2'b11;	// Both cores refresh
				stores++;
			end
			else
				rejects++;
			compare("rsp_strand", 32'(rsp_strand), 32'(head.strand));
			compare("rsp_op", 32'(rsp_op), 32'(head.op));
			compare("rsp_address", 32'(rsp_address), 32'(head.address));
			compare("rsp_status", 32'(rsp_status), 32'(exp_status));
			compare("rsp_data", rsp_data, exp_data);
			compare("rsp_update", 32'(rsp_update), 32'(exp_update));
		end
		rsp_count++;
	endtask

	task automatic end_checks();
		compare("pc_load_count", 32'(pc_load_count), 32'(loads));
		compare("pc_store_count", 32'(pc_store_count), 32'(stores));
		compare("pc_error_count", 32'(pc_error_count), 32'(rejects));
		compare("credit_return_0 pulses", 32'(credits_back[0]), 32'(accepted[0]));
		compare("credit_return_1 pulses", 32'(credits_back[1]), 32'(accepted[1]));
		compare("responses", 32'(rsp_count), 32'(accepted[0] + accepted[1]));	// No duplicates
	endtask

	// Samples every port on the rising clock edge
	always @(posedge reset or posedge clk)
	begin
		if (clk)
		begin
			queue_0.delete();
			queue_1.delete();
			for (int i = 0; i < 64; i++)
				model_mem[i] = '0;	// Store is cleared at reset
			accepted = '{0, 0};
			credits_back = '{0, 0};
			loads = 0;
			stores = 0;
			rejects = 0;
			pending = 0;
			error_count = 0;
			rsp_count = 0;
			end_done = 1'b0;
		end
		else
		begin
			if (rsp_valid)
				check_response();	// Older than any request seen this edge
			if (credit_return_0)
				credits_back[0]++;
			if (credit_return_1)
				credits_back[1]++;
			if (req_valid_0)
			begin
				queue_0.push_back('{strand: req_strand_0, op: req_op_0, address: req_address_0,
					data: req_data_0, mask: req_mask_0});
				accepted[0]++;
			end
			if (req_valid_1)
			begin
				queue_1.push_back('{strand: req_strand_1, op: req_op_1, address: req_address_1,
					data: req_data_1, mask: req_mask_1});
				accepted[1]++;
			end
			pending = queue_0.size() + queue_1.size();
			if (end_check && !end_done)
			begin
				end_checks();
				end_done = 1'b1;
			end
		end
	end

endmodule

/* verif/tb_l2_subsystem.sv */
`timescale 1ns/1ps

module tb_l2_subsystem;
	import l2_pkg::*;

	localparam int REQ_CREDITS = 4;
	localparam int TABLE_SIZE = 24;
	localparam int WAIT_LIMIT = 200;	// Cycles before any wait gives up
	localparam int M_SAME = 0;	// Same cycle as the previous entry, other core
	localparam int M_NEXT = 1;	// Next cycle, no gap
	localparam int M_GAP = 2;	// Random idle cycles first

	logic reset;	// Clock
	logic clk;	// Reset, active high
	logic req_valid_0;
	strand_t req_strand_0;
	l2_op_t req_op_0;
	l2_addr_t req_address_0;
	l2_data_t req_data_0;
	l2_mask_t req_mask_0;
	logic req_valid_1;
	strand_t req_strand_1;
	l2_op_t req_op_1;
	l2_addr_t req_address_1;
	l2_data_t req_data_1;
	l2_mask_t req_mask_1;
	logic credit_return_0;
	logic credit_return_1;
	logic rsp_valid;
	core_t rsp_core;
	strand_t rsp_strand;
	l2_op_t rsp_op;
	logic rsp_status;
	l2_addr_t rsp_address;
	l2_data_t rsp_data;
	logic [NUM_CORES-1:0] rsp_update;
	pc_count_t pc_load_count;
	pc_count_t pc_store_count;
	pc_count_t pc_error_count;
	logic end_check;
	logic end_done;
	int pending;
	int error_count;
	int rsp_count;

	core_t tab_core [TABLE_SIZE];	// Stimulus table
	strand_t tab_strand [TABLE_SIZE];
	l2_op_t tab_op [TABLE_SIZE];
	l2_addr_t tab_address [TABLE_SIZE];
	l2_data_t tab_data [TABLE_SIZE];
	l2_mask_t tab_mask [TABLE_SIZE];
	int tab_mode [TABLE_SIZE];
	int entry_count;
	int sent [2];	// Core credit models
	int returned [2];
	int seed;
	bit timed_out;

	always #5 reset = ~reset;	// 10 ns period

	l2_subsystem #(.REQ_CREDITS(REQ_CREDITS)) i_l2_subsystem (
		.reset(reset), .clk(clk),
		.req_valid_0(req_valid_0), .req_strand_0(req_strand_0), .req_op_0(req_op_0),
		.req_address_0(req_address_0), .req_data_0(req_data_0), .req_mask_0(req_mask_0),
		.req_valid_1(req_valid_1), .req_strand_1(req_strand_1), .req_op_1(req_op_1),
		.req_address_1(req_address_1), .req_data_1(req_data_1), .req_mask_1(req_mask_1),
		.credit_return_0(credit_return_0), .credit_return_1(credit_return_1),
		.rsp_valid(rsp_valid), .rsp_core(rsp_core), .rsp_strand(rsp_strand), .rsp_op(rsp_op),
		.rsp_status(rsp_status), .rsp_address(rsp_address), .rsp_data(rsp_data),
		.rsp_update(rsp_update), .pc_load_count(pc_load_count),
		.pc_store_count(pc_store_count), .pc_error_count(pc_error_count)
	);

	l2_checker i_l2_checker (
		.reset(reset), .clk(clk),
		.req_valid_0(req_valid_0), .req_strand_0(req_strand_0), .req_op_0(req_op_0),
		.req_address_0(req_address_0), .req_data_0(req_data_0), .req_mask_0(req_mask_0),
		.req_valid_1(req_valid_1), .req_strand_1(req_strand_1), .req_op_1(req_op_1),
		.req_address_1(req_address_1), .req_data_1(req_data_1), .req_mask_1(req_mask_1),
		.credit_return_0(credit_return_0), .credit_return_1(credit_return_1),
		.rsp_valid(rsp_valid), .rsp_core(rsp_core), .rsp_strand(rsp_strand), .rsp_op(rsp_op),
		.rsp_status(rsp_status), .rsp_address(rsp_address), .rsp_data(rsp_data),
		.rsp_update(rsp_update), .pc_load_count(pc_load_count),
		.pc_store_count(pc_store_count), .pc_error_count(pc_error_count),
		.end_check(end_check), .end_done(end_done), .pending(pending),
		.error_count(error_count), .rsp_count(rsp_count)
	);

	// Credits come back on the edge that frees the queue slot
	always @(posedge reset)
	begin
		if (!clk)
		begin
			if (credit_return_0)
				returned[0]++;
			if (credit_return_1)
				returned[1]++;
		end
	end

	function automatic int credits_held(input core_t core);
		return REQ_CREDITS - sent[core] + returned[core];
	endfunction

	task automatic add_entry(input core_t core, input strand_t strand, input l2_op_t op,
		input l2_addr_t address, input l2_data_t data, input l2_mask_t mask, input int mode);
		tab_core[entry_count] = core;
		tab_strand[entry_count] = strand;
		tab_op[entry_count] = op;
		tab_address[entry_count] = address;
		tab_data[entry_count] = data;
		tab_mask[entry_count] = mask;
		tab_mode[entry_count] = mode;
		entry_count++;
	endtask

	task automatic fill_table();
		add_entry(1'b0, 2'd0, OP_STORE, 6'h05, 32'h11223344, 4'hf, M_GAP);	// Full word
		add_entry(1'b0, 2'd1, OP_LOAD, 6'h05, 32'h0, 4'h0, M_NEXT);	// Load right behind store
		add_entry(1'b0, 2'd2, OP_STORE, 6'h05, 32'haabbccdd, 4'h1, M_GAP);
		add_entry(1'b0, 2'd3, OP_LOAD, 6'h05, 32'h0, 4'h0, M_NEXT);
		add_entry(1'b1, 2'd0, OP_STORE, 6'h0a, 32'hcafef00d, 4'h6, M_GAP);
		add_entry(1'b1, 2'd1, OP_LOAD, 6'h0a, 32'h0, 4'h0, M_NEXT);
		add_entry(1'b1, 2'd2, OP_STORE, 6'h0a, 32'h12345678, 4'h9, M_GAP);
		add_entry(1'b1, 2'd3, OP_LOAD, 6'h0a, 32'h0, 4'h0, M_GAP);
		add_entry(1'b0, 2'd0, OP_STORE, 6'h10, 32'hdeadbeef, 4'ha, M_GAP);
		add_entry(1'b0, 2'd1, OP_LOAD, 6'h10, 32'h0, 4'h0, M_NEXT);
		add_entry(1'b1, 2'd0, OP_STORE, 6'h10, 32'h0badc0de, 4'h5, M_SAME);	// Both cores at once
		add_entry(1'b0, 2'd2, 3'd3, 6'h05, 32'hffffffff, 4'hf, M_GAP);	// Invalid op code
		add_entry(1'b0, 2'd3, OP_LOAD, 6'h05, 32'h0, 4'h0, M_NEXT);	// Word must be unchanged
		add_entry(1'b1, 2'd1, 3'd7, 6'h0a, 32'h55aa55aa, 4'hf, M_SAME);
		add_entry(1'b1, 2'd2, OP_LOAD, 6'h0a, 32'h0, 4'h0, M_NEXT);
		add_entry(1'b1, 2'd0, OP_STORE, 6'h20, 32'h01010101, 4'h3, M_GAP);	// Credit burst
		add_entry(1'b1, 2'd1, OP_STORE, 6'h21, 32'h02020202, 4'hc, M_NEXT);
		add_entry(1'b1, 2'd2, OP_LOAD, 6'h20, 32'h0, 4'h0, M_NEXT);
		add_entry(1'b1, 2'd3, OP_LOAD, 6'h21, 32'h0, 4'h0, M_NEXT);
		add_entry(1'b0, 2'd0, OP_LOAD, 6'h20, 32'h0, 4'h0, M_GAP);	// Cross-core reads
		add_entry(1'b1, 2'd0, OP_LOAD, 6'h10, 32'h0, 4'h0, M_SAME);
		add_entry(1'b0, 2'd1, OP_STORE, 6'h3f, 32'hfeedface, 4'he, M_NEXT);
		add_entry(1'b1, 2'd1, OP_LOAD, 6'h3f, 32'h0, 4'h0, M_SAME);
		add_entry(1'b0, 2'd2, OP_LOAD, 6'h3f, 32'h0, 4'h0, M_NEXT);
	endtask

	task automatic idle_requests();
		req_valid_0 = 1'b0;
		req_valid_1 = 1'b0;
	endtask

	task automatic wait_for_credit(input core_t core);
		int cycles;
		cycles = 0;
		while (credits_held(core) == 0 && cycles < WAIT_LIMIT)
		begin
			@(negedge reset);
			idle_requests();	// Valid lasts one cycle only
			cycles++;
		end
		if (credits_held(core) == 0)
		begin
			$display("Timed out waiting for a credit on core %0d", core);
			timed_out = 1'b1;
		end
	endtask

	task automatic send_entry(input int idx);
		if (tab_core[idx])
		begin
			req_valid_1 = 1'b1;
			req_strand_1 = tab_strand[idx];
			req_op_1 = tab_op[idx];
			req_address_1 = tab_address[idx];
			req_data_1 = tab_data[idx];
			req_mask_1 = tab_mask[idx];
		end
		else
		begin
			req_valid_0 = 1'b1;
			req_strand_0 = tab_strand[idx];
			req_op_0 = tab_op[idx];
			req_address_0 = tab_address[idx];
			req_data_0 = tab_data[idx];
			req_mask_0 = tab_mask[idx];
		end
		sent[tab_core[idx]]++;	// One credit used
	endtask

	task automatic run_stimulus();
		int gap;
		for (int i = 0; i < entry_count && !timed_out; i++)
		begin
			if (tab_mode[i] != M_SAME)
			begin
				@(negedge reset);
				idle_requests();
				if (tab_mode[i] == M_GAP)
				begin
					gap = 2 + int'($unsigned($random(seed)) % 4);
					repeat (gap) @(negedge reset);
				end
			end
			wait_for_credit(tab_core[i]);
			if (!timed_out)
				send_entry(i);
		end
		@(negedge reset);
		idle_requests();
	endtask

	task automatic wait_for_drain();
		int cycles;
		cycles = 0;
		while (pending != 0 && cycles < WAIT_LIMIT)
		begin
			@(negedge reset);
			cycles++;
		end
		if (pending != 0)
		begin
			$display("Timed out with %0d requests still waiting for a response", pending);
			timed_out = 1'b1;
		end
	endtask

	task automatic wait_for_end_check();
		int cycles;
		cycles = 0;
		while (!end_done && cycles < WAIT_LIMIT)
		begin
			@(negedge reset);
			cycles++;
		end
		if (!end_done)
		begin
			$display("Timed out waiting for the checker's closing comparisons");
			timed_out = 1'b1;
		end
	endtask

	initial
	begin
		reset = 1'b0;
		clk = 1'b1;	// Reset held from time zero
		req_valid_0 = 1'b0;
		req_strand_0 = '0;
		req_op_0 = '0;
		req_address_0 = '0;
		req_data_0 = '0;
		req_mask_0 = '0;
		req_valid_1 = 1'b0;
		req_strand_1 = '0;
		req_op_1 = '0;
		req_address_1 = '0;
		req_data_1 = '0;
		req_mask_1 = '0;
		end_check = 1'b0;
		seed = 84;
		timed_out = 1'b0;
		entry_count = 0;
		sent = '{0, 0};
		returned = '{0, 0};
		fill_table();
		repeat (16) @(negedge reset);
		clk = 1'b0;
		run_stimulus();
		if (!timed_out)
			wait_for_drain();
		if (!timed_out)
		begin
			end_check = 1'b1;
			wait_for_end_check();
		end
		$display("Closing report: %0d responses, %0d check errors, %0d timeouts",
			rsp_count, error_count, timed_out);
		if (!timed_out && error_count == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

/* l2_subsystem.f */
hdl/l2_pkg.sv
hdl/l2_request_queue.sv
hdl/l2_arbiter.sv
hdl/l2_decode.sv
hdl/l2_execute.sv
hdl/l2_result.sv
hdl/performance_counters.sv
hdl/l2_subsystem.sv
verif/l2_checker.sv
verif/tb_l2_subsystem.sv

/* Makefile */
SOURCES := $(shell cat l2_subsystem.f)

obj_dir/Vtb_l2_subsystem: l2_subsystem.f $(SOURCES)
	verilator --binary --timing --top-module tb_l2_subsystem -f l2_subsystem.f -o Vtb_l2_subsystem

run: obj_dir/Vtb_l2_subsystem
	@out="$$(./obj_dir/Vtb_l2_subsystem)"; echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir

.PHONY: run clean
